// File: common/sha_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SHA-256 word and schedule types, round constants,
// initial hash and controller states
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package sha_pkg;

  typedef logic [31:0] word_t;       // Data word
  typedef logic [5:0]  sched_addr_t; // Schedule index t

  typedef struct packed {
    word_t a;  // H0 when used as hash
    word_t b;
    word_t c;
    word_t d;
    word_t e;
    word_t f;
    word_t g;
    word_t h;  // H7
  } hash_state_t;

  typedef struct packed {
    logic        en;
    sched_addr_t addr;
    word_t       data;
  } sched_wr_t;

  typedef struct packed {
    word_t w2;   // W[t-2]
    word_t w7;   // W[t-7]
    word_t w15;  // W[t-15]
    word_t w16;  // W[t-16]
  } sched_taps_t;

  localparam int BLOCK_WORDS = 16;  // Words per message block
  localparam int ROUNDS      = 64;

  // FIPS 180-4 sec. 4.2.2
  localparam word_t K_ROUND [ROUNDS] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // Initial hash, sec. 5.3.3
  localparam hash_state_t H_INIT = '{
    a: 32'h6a09e667, b: 32'hbb67ae85, c: 32'h3c6ef372, d: 32'ha54ff53a,
    e: 32'h510e527f, f: 32'h9b05688c, g: 32'h1f83d9ab, h: 32'h5be0cd19
  };

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,     // Schedule being built
    ST_COMPRESS,  // Rounds running
    ST_WRITE,     // Digest to RAM
    ST_FINISH
  } ctrl_state_t;

endpackage

// File: common/mem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// External RAM address, block count and write bus
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package mem_pkg;
  import sha_pkg::*;

  typedef logic [11:0] ram_addr_t;  // 4096 word RAM
  typedef logic [15:0] blk_cnt_t;   // Message blocks to hash

  localparam ram_addr_t DIGEST_BASE = 12'h000;  // H0 lands here

  typedef struct packed {
    logic      en;
    ram_addr_t addr;
    word_t     data;
  } ram_wr_t;

endpackage

// File: sched/sched_ram.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 64 x 32 schedule memory, tap and round reads
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module sched_ram import sha_pkg::*; (
  input  logic        clk,
  input  sched_wr_t   sched_wr,
  input  sched_addr_t tap_t,
  output sched_taps_t taps,
  input  sched_addr_t round_t,
  output word_t       w_t
);

  word_t       mem [ROUNDS];
  sched_addr_t a2;
  sched_addr_t a7;
  sched_addr_t a15;
  sched_addr_t a16;

  assign a2  = tap_t - 6'd2;
  assign a7  = tap_t - 6'd7;
  assign a15 = tap_t - 6'd15;
  assign a16 = tap_t - 6'd16;  // Wraps below 16, unused then

  always_ff @(posedge clk) begin
    if (sched_wr.en) begin
      mem[sched_wr.addr] <= sched_wr.data;
    end
    taps.w2  <= mem[a2];   // Registered reads, old data on collision
    taps.w7  <= mem[a7];
    taps.w15 <= mem[a15];
    taps.w16 <= mem[a16];
    w_t      <= mem[round_t];
  end

endmodule

// File: sched/msg_sched.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Message load from RAM and W[16..63] expansion
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module msg_sched import sha_pkg::*, mem_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        msg_start,
  input  logic        fetch_start,
  output ram_addr_t   ram_rd_addr,  // Runs across blocks
  input  word_t       ram_rd_data,
  output sched_addr_t tap_t,
  input  sched_taps_t taps,
  output sched_wr_t   sched_wr,
  output logic        sched_done
);

  typedef enum logic [2:0] {
    SC_IDLE,
    SC_LD_ADDR,   // RAM address out
    SC_LD_WR,     // RAM data into W[t]
    SC_EXP_RD,    // Tap read
    SC_EXP_WR     // Expanded W[t] written
  } sc_state_t;

  sc_state_t   state;
  sched_addr_t t;
  word_t       s0;
  word_t       s1;
  word_t       w_new;

  // Small sigma 1 on W[t-2], small sigma 0 on W[t-15]
  assign s1 = {taps.w2[16:0], taps.w2[31:17]} ^ {taps.w2[18:0], taps.w2[31:19]}
            ^ (taps.w2 >> 10);
  assign s0 = {taps.w15[6:0], taps.w15[31:7]} ^ {taps.w15[17:0], taps.w15[31:18]}
            ^ (taps.w15 >> 3);
  assign w_new = s1 + taps.w7 + s0 + taps.w16;

  assign tap_t    = t;  // sched_ram derives t-2 .. t-16
  assign sched_wr = '{
    en:   (state == SC_LD_WR) || (state == SC_EXP_WR),
    addr: t,
    data: (state == SC_LD_WR) ? ram_rd_data : w_new
  };

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state       <= SC_IDLE;
      t           <= '0;
      ram_rd_addr <= '0;
      sched_done  <= 1'b0;
    end else begin
      sched_done <= 1'b0;
      if (msg_start) begin
        ram_rd_addr <= '0;  // New message from address 0
      end
      case (state)
        SC_IDLE: begin
          if (fetch_start) begin
            t     <= '0;
            state <= SC_LD_ADDR;
          end
        end
        SC_LD_ADDR: state <= SC_LD_WR;
        SC_LD_WR: begin
          ram_rd_addr <= ram_rd_addr + 1'b1;
          t           <= t + 1'b1;
          if (t == sched_addr_t'(BLOCK_WORDS - 1)) begin
            state <= SC_EXP_RD;  // t now 16
          end else begin
            state <= SC_LD_ADDR;
          end
        end
        SC_EXP_RD: state <= SC_EXP_WR;
        SC_EXP_WR: begin
          if (t == sched_addr_t'(ROUNDS - 1)) begin
            sched_done <= 1'b1;  // W63 written
            state      <= SC_IDLE;
          end else begin
            t     <= t + 1'b1;
            state <= SC_EXP_RD;
          end
        end
        default: state <= SC_IDLE;
      endcase
    end
  end

endmodule

// File: round/sha256_rounds.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Compression rounds and intermediate hash
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module sha256_rounds import sha_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        init_h,
  input  logic        compress_start,
  output sched_addr_t round_t,
  input  word_t       w_t,
  output hash_state_t hash,
  output logic        compress_done
);

  typedef enum logic [1:0] {
    R_IDLE,
    R_READ,    // W[t] address to sched_ram
    R_UPDATE,  // Working variables step
    R_ADD      // Fold into hash
  } rnd_state_t;

  rnd_state_t  state;
  sched_addr_t t;
  hash_state_t wv;       // a..h working variables
  word_t       big_s0;
  word_t       big_s1;
  word_t       ch;
  word_t       maj;
  word_t       t1;
  word_t       t2;

  assign round_t = t;

  assign big_s1 = {wv.e[5:0], wv.e[31:6]} ^ {wv.e[10:0], wv.e[31:11]}
                ^ {wv.e[24:0], wv.e[31:25]};
  assign ch     = (wv.e & wv.f) ^ (~wv.e & wv.g);
  assign t1     = wv.h + big_s1 + ch + K_ROUND[t] + w_t;
  assign big_s0 = {wv.a[1:0], wv.a[31:2]} ^ {wv.a[12:0], wv.a[31:13]}
                ^ {wv.a[21:0], wv.a[31:22]};
  assign maj    = (wv.a & wv.b) ^ (wv.a & wv.c) ^ (wv.b & wv.c);
  assign t2     = big_s0 + maj;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state         <= R_IDLE;
      t             <= '0;
      compress_done <= 1'b0;
    end else begin
      compress_done <= 1'b0;
      case (state)
        R_IDLE: begin
          if (compress_start) begin
            t     <= '0;
            state <= R_READ;
          end
        end
        R_READ: state <= R_UPDATE;  // w_t valid next cycle
        R_UPDATE: begin
          if (t == sched_addr_t'(ROUNDS - 1)) begin
            state <= R_ADD;
          end else begin
            t     <= t + 1'b1;
            state <= R_READ;
          end
        end
        R_ADD: begin
          compress_done <= 1'b1;    // Lines up with new hash
          state         <= R_IDLE;
        end
        default: state <= R_IDLE;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge clk) begin
    if (init_h) begin
      hash <= H_INIT;
    end else if (state == R_ADD) begin
      hash <= '{
        a: hash.a + wv.a, b: hash.b + wv.b, c: hash.c + wv.c, d: hash.d + wv.d,
        e: hash.e + wv.e, f: hash.f + wv.f, g: hash.g + wv.g, h: hash.h + wv.h
      };
    end
    if ((state == R_IDLE) && compress_start) begin
      wv <= hash;                   // Start of block
    end else if (state == R_UPDATE) begin
      wv <= '{
        a: t1 + t2, b: wv.a, c: wv.b, d: wv.c,
        e: wv.d + t1, f: wv.e, g: wv.f, h: wv.g
      };
    end
  end

endmodule

// File: rtl/sha256_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Block sequencer, busy/RAM select and digest write-back
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module sha256_ctrl import sha_pkg::*, mem_pkg::*; (
  input  logic        clk,
  input  logic        reset_n,
  input  logic        go,
  input  blk_cnt_t    num_blocks,
  input  logic        sched_done,
  input  logic        compress_done,
  input  hash_state_t hash,
  output logic        msg_start,       // Rewind RAM read pointer
  output logic        fetch_start,     // Build schedule for next block
  output logic        compress_start,
  output logic        init_h,          // Load H_INIT
  output ram_wr_t     ram_wr,
  output logic        ram_sel,
  output logic        busy
);

  ctrl_state_t state;
  blk_cnt_t    blk_cnt;   // Blocks still to compress
  logic [2:0]  wr_idx;    // Digest word select
  word_t       hash_word;

  // H0 sits in the top word of the struct
  assign hash_word = hash[{3'd7 - wr_idx, 5'd0} +: 32];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state          <= ST_IDLE;
      blk_cnt        <= '0;
      wr_idx         <= '0;
      msg_start      <= 1'b0;
      fetch_start    <= 1'b0;
      compress_start <= 1'b0;
      init_h         <= 1'b0;
      ram_wr         <= '0;
      ram_sel        <= 1'b0;
      busy           <= 1'b0;
    end else begin
      msg_start      <= 1'b0;       // Pulses by default
      init_h         <= 1'b0;
      compress_start <= 1'b0;
      ram_wr.en      <= 1'b0;
      fetch_start    <= msg_start;  // First fetch trails msg_start
      case (state)
        ST_IDLE: begin
          if (go) begin             // go only seen here
            busy      <= 1'b1;
            ram_sel   <= 1'b1;
            init_h    <= 1'b1;
            msg_start <= 1'b1;
            blk_cnt   <= num_blocks;
            state     <= ST_FETCH;
          end
        end
        ST_FETCH: begin
          if (sched_done) begin
            compress_start <= 1'b1;
            state          <= ST_COMPRESS;
          end
        end
        ST_COMPRESS: begin
          if (compress_done) begin  // Hash already chained
            blk_cnt <= blk_cnt - 1'b1;
            if (blk_cnt > blk_cnt_t'(1)) begin
              fetch_start <= 1'b1;
              state       <= ST_FETCH;
            end else begin
              wr_idx <= '0;
              state  <= ST_WRITE;
            end
          end
        end
        ST_WRITE: begin             // One word per cycle, H0 first
          ram_wr <= '{en: 1'b1, addr: DIGEST_BASE + ram_addr_t'(wr_idx), data: hash_word};
          wr_idx <= wr_idx + 1'b1;
          if (wr_idx == 3'd7) begin
            state <= ST_FINISH;
          end
        end
        ST_FINISH: begin            // Last write on the bus now
          busy    <= 1'b0;
          ram_sel <= 1'b0;
          state   <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// File: rtl/sha256_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SHA-256 core top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module sha256_top import sha_pkg::*, mem_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  logic      go,           // Host start pulse
  input  blk_cnt_t  num_blocks,   // Padded blocks in RAM
  output ram_addr_t ram_rd_addr,
  input  word_t     ram_rd_data,
  output ram_wr_t   ram_wr,
  output logic      ram_sel,      // Core owns RAM
  output logic      busy
);

  logic        msg_start;
  logic        fetch_start;
  logic        sched_done;
  logic        init_h;
  logic        compress_start;
  logic        compress_done;
  hash_state_t hash;
  sched_wr_t   sched_wr;
  sched_addr_t tap_t;
  sched_taps_t taps;
  sched_addr_t round_t;
  word_t       w_t;

  sha256_ctrl ctrl_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .go             (go),
    .num_blocks     (num_blocks),
    .sched_done     (sched_done),
    .compress_done  (compress_done),
    .hash           (hash),
    .msg_start      (msg_start),
    .fetch_start    (fetch_start),
    .compress_start (compress_start),
    .init_h         (init_h),
    .ram_wr         (ram_wr),
    .ram_sel        (ram_sel),
    .busy           (busy)
  );

  msg_sched sched_i (  // Producer
    .clk         (clk),
    .reset_n     (reset_n),
    .msg_start   (msg_start),
    .fetch_start (fetch_start),
    .ram_rd_addr (ram_rd_addr),
    .ram_rd_data (ram_rd_data),
    .tap_t       (tap_t),
    .taps        (taps),
    .sched_wr    (sched_wr),
    .sched_done  (sched_done)
  );

  sched_ram sram_i (  // One block of W[t]
    .clk      (clk),
    .sched_wr (sched_wr),
    .tap_t    (tap_t),
    .taps     (taps),
    .round_t  (round_t),
    .w_t      (w_t)
  );

  sha256_rounds rounds_i (  // Consumer
    .clk            (clk),
    .reset_n        (reset_n),
    .init_h         (init_h),
    .compress_start (compress_start),
    .round_t        (round_t),
    .w_t            (w_t),
    .hash           (hash),
    .compress_done  (compress_done)
  );

endmodule

// File: sim/sha256_model.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SHA-256 reference compression, digest and
// message padding for the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef SHA256_MODEL_SVH
`define SHA256_MODEL_SVH

typedef logic [7:0] byte_q_t [$];  // Message bytes
typedef word_t      word_q_t [$];  // Padded message words

function automatic word_t rotr(word_t x, int n);
  return (x >> n) | (x << (32 - n));
endfunction

// One 512-bit block, word 0 in the top bits
function automatic hash_state_t model_compress(hash_state_t hin, logic [511:0] blk);
  word_t       w [64];
  word_t       v [8];   // a..h
  word_t       t1;
  word_t       t2;
  hash_state_t hout;
  for (int i = 0; i < 16; i++) begin
    w[i] = blk[511 - 32*i -: 32];
  end
  for (int i = 16; i < 64; i++) begin
    w[i] = (rotr(w[i-2], 17) ^ rotr(w[i-2], 19) ^ (w[i-2] >> 10)) + w[i-7]
         + (rotr(w[i-15], 7) ^ rotr(w[i-15], 18) ^ (w[i-15] >> 3)) + w[i-16];
  end
  {v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7]} = hin;
  for (int i = 0; i < 64; i++) begin
    t1 = v[7] + (rotr(v[4], 6) ^ rotr(v[4], 11) ^ rotr(v[4], 25))
       + ((v[4] & v[5]) ^ (~v[4] & v[6])) + K_ROUND[i] + w[i];
    t2 = (rotr(v[0], 2) ^ rotr(v[0], 13) ^ rotr(v[0], 22))
       + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
    for (int j = 7; j > 0; j--) begin
      v[j] = v[j-1];         // Shift down the chain
    end
    v[4] = v[4] + t1;        // Old d plus T1
    v[0] = t1 + t2;
  end
  for (int j = 0; j < 8; j++) begin
    hout[255 - 32*j -: 32] = hin[255 - 32*j -: 32] + v[j];
  end
  return hout;
endfunction

// Digest over all blocks, chained from the FIPS initial hash
function automatic hash_state_t model_digest(word_q_t words);
  hash_state_t  hs;
  logic [511:0] blk;
  hs = '{a: 32'h6a09e667, b: 32'hbb67ae85, c: 32'h3c6ef372, d: 32'ha54ff53a,
         e: 32'h510e527f, f: 32'h9b05688c, g: 32'h1f83d9ab, h: 32'h5be0cd19};
  for (int b = 0; b < words.size() / 16; b++) begin
    for (int i = 0; i < 16; i++) begin
      blk[511 - 32*i -: 32] = words[16*b + i];
    end
    hs = model_compress(hs, blk);
  end
  return hs;
endfunction

// 0x80, zero fill to 56 mod 64, then 64-bit big endian bit length
function automatic word_q_t pad_message(byte_q_t msg);
  byte_q_t     b;
  word_q_t     words;
  logic [63:0] bit_len;
  b = msg;
  bit_len = 64'(msg.size()) * 64'd8;
  b.push_back(8'h80);
  while (b.size() % 64 != 56) begin
    b.push_back(8'h00);
  end
  for (int i = 7; i >= 0; i--) begin
    b.push_back(bit_len[8*i +: 8]);
  end
  for (int i = 0; i < b.size(); i += 4) begin
    words.push_back({b[i], b[i+1], b[i+2], b[i+3]});
  end
  return words;
endfunction

`endif

// File: sim/tb_sha256.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// SHA-256 core testbench, RAM model and checks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_sha256 import sha_pkg::*, mem_pkg::*; ();

  `include "sha256_model.svh"

  localparam int WAIT_LIMIT = 4000;  // Cycles per hash run
  localparam hash_state_t ABC_DIGEST = '{
    a: 32'hba7816bf, b: 32'h8f01cfea, c: 32'h414140de, d: 32'h5dae2223,
    e: 32'hb00361a3, f: 32'h96177a9c, g: 32'hb410ff61, h: 32'hf20015ad
  };

  logic        clk;
  logic        reset_n;
  logic        go;
  blk_cnt_t    num_blocks;
  ram_addr_t   ram_rd_addr;
  word_t       ram_rd_data = '0;
  ram_wr_t     ram_wr;
  logic        ram_sel;
  logic        busy;
  ram_wr_t     ld;                // Host preload port of the RAM
  logic        go_seen;
  logic        wr_en;
  ram_addr_t   wr_addr;
  word_t       ram_mem [4096];
  logic [15:0] lfsr = 16'd9;
  byte_q_t     msg;
  word_q_t     words;
  hash_state_t expect_hash;

  assign wr_en   = ram_wr.en;
  assign wr_addr = ram_wr.addr;

  sha256_top dut_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .go          (go),
    .num_blocks  (num_blocks),
    .ram_rd_addr (ram_rd_addr),
    .ram_rd_data (ram_rd_data),
    .ram_wr      (ram_wr),
    .ram_sel     (ram_sel),
    .busy        (busy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Synchronous read with one cycle latency
  always @(posedge clk) begin
    ram_rd_data <= ram_mem[ram_rd_addr];
    if (ld.en) begin
      ram_mem[ld.addr] <= ld.data;
    end
    if (ram_wr.en) begin
      ram_mem[ram_wr.addr] <= ram_wr.data;  // Digest write-back
    end
  end

  function automatic string error_text(string what);
    return $sformatf("** Error at %0t: %s", $time, what);
  endfunction

  task automatic stop_run(string line);
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1);
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_step();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] rand_byte();
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < 8; i++) begin
      r = {r[6:0], lfsr_step()};  // One step per bit
    end
    return r;
  endfunction

  // Protocol checks on the host side
  assert property (@(posedge clk) disable iff (!reset_n) busy == ram_sel)
    else stop_run(error_text("busy and ram_sel differ"));
  assert property (@(posedge clk) disable iff (!reset_n) wr_en |-> busy)
    else stop_run(error_text("RAM write while busy is low"));
  assert property (@(posedge clk) disable iff (!reset_n)
                   !go_seen |-> !busy && !ram_sel && !wr_en)
    else stop_run(error_text("outputs active before the first go"));
  assert property (@(posedge clk) disable iff (!reset_n) go && !busy |=> busy)
    else stop_run(error_text("busy did not rise one cycle after go"));
  assert property (@(posedge clk) disable iff (!reset_n) $rose(busy) |-> $past(go))
    else stop_run(error_text("busy rose without go"));
  assert property (@(posedge clk) disable iff (!reset_n) $rose(wr_en) |-> wr_addr == DIGEST_BASE)
    else stop_run(error_text("first digest write not at DIGEST_BASE"));
  assert property (@(posedge clk) disable iff (!reset_n)
                   wr_en && $past(wr_en) |-> wr_addr == $past(wr_addr) + 12'd1)
    else stop_run(error_text("digest write addresses not consecutive"));
  assert property (@(posedge clk) disable iff (!reset_n)
                   $fell(busy) |-> $past(wr_en) && $past(wr_addr) == DIGEST_BASE + 12'd7)
    else stop_run(error_text("busy did not fall right after the eighth write"));
  assert property (@(posedge clk) disable iff (!reset_n) $fell(wr_en) |-> !busy)
    else stop_run(error_text("digest writes stopped before busy fell"));

  task automatic load_ram(word_q_t w);
    foreach (w[i]) begin
      @(posedge clk);
      ld <= '{en: 1'b1, addr: ram_addr_t'(i), data: w[i]};
    end
    @(posedge clk);
    ld.en <= 1'b0;
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);          // Outputs settled here
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        stop_run("Timeout: busy did not fall within the cycle limit");
      end
    end while (busy);
  endtask

  // Load, start, optionally pulse go again mid-run, then wait for the end
  task automatic run_hash(word_q_t w, bit extra_go);
    load_ram(w);
    @(posedge clk);
    num_blocks <= blk_cnt_t'(w.size() / 16);
    go         <= 1'b1;
    go_seen    <= 1'b1;
    @(posedge clk);
    go <= 1'b0;
    if (extra_go) begin
      repeat (40) @(posedge clk);
      go <= 1'b1;              // Must be ignored while busy
      @(posedge clk);
      go <= 1'b0;
    end
    wait_idle();
  endtask

  task automatic check_digest(hash_state_t exp, string name);
    word_t want;
    word_t got;
    for (int i = 0; i < 8; i++) begin
      want = exp[255 - 32*i -: 32];  // H0 first
      got  = ram_mem[DIGEST_BASE + ram_addr_t'(i)];
      assert (got == want)
        else stop_run(error_text($sformatf("%s H%0d is %h, expected %h", name, i, got, want)));
    end
  endtask

  initial begin
    reset_n    = 1'b0;
    go         = 1'b0;
    num_blocks = '0;
    ld         = '0;
    go_seen    = 1'b0;
    repeat (10) @(posedge clk);
    reset_n <= 1'b1;
    repeat (5) @(posedge clk);

    // FIPS example "abc" in one block
    msg   = {8'h61, 8'h62, 8'h63};
    words = pad_message(msg);
    assert (model_digest(words) == ABC_DIGEST)
      else stop_run(error_text("reference model disagrees with the abc digest"));
    run_hash(words, 1'b0);
    check_digest(ABC_DIGEST, "abc");

    // 150 random bytes pad to three blocks
    msg = {};
    repeat (150) msg.push_back(rand_byte());
    words = pad_message(msg);
    assert (words.size() == 48)
      else stop_run(error_text($sformatf("padded size %0d words, expected 48", words.size())));
    expect_hash = model_digest(words);
    run_hash(words, 1'b1);
    check_digest(expect_hash, "random");

    // Same message again restarts from H_INIT
    run_hash(words, 1'b0);
    check_digest(expect_hash, "repeat");

    $display("Finished with no errors");
    $finish;
  end

endmodule

// File: list.f
+incdir+sim
common/sha_pkg.sv
common/mem_pkg.sv
sched/sched_ram.sv
sched/msg_sched.sv
round/sha256_rounds.sv
rtl/sha256_ctrl.sv
rtl/sha256_top.sv
sim/tb_sha256.sv

// File: Makefile
# Verilator build and run of the SHA-256 core testbench

VERILATOR ?= verilator
TOP       ?= tb_sha256
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "TEST PASSED"; \
	else \
	  echo "TEST FAILED"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
